/* hw/sync_account_intake.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Account intake stage
// Pops accounts, holds them on barrier hazard or release back-pressure
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module sync_account_intake import sync_pkg::*; (
	input logic clk,
	input logic reset,
	// Account queue head
	input sync_account_message_t head,
	input logic head_valid,
	output logic pop,
	// Release queue back-pressure
	input logic release_almost_full,
	// Barriers in flight downstream
	input logic [barrier_id_width-1:0] s2_id,
	input logic [barrier_id_width-1:0] s3_id,
	input slot_state_t s2_state,
	input slot_state_t s3_state,
	// Stage 1 slot
	output sync_account_message_t s1_mess,
	output slot_state_t s1_state
);

	logic hit_s1;
	logic hit_s2;
	logic hit_s3;
	logic hazard;

	// Own slot also holds an account that has not read the memory yet
	assign hit_s1 = (s1_state == slot_busy) && (s1_mess.id_barrier == head.id_barrier);
	assign hit_s2 = (s2_state == slot_busy) && (s2_id == head.id_barrier);
	assign hit_s3 = (s3_state == slot_busy) && (s3_id == head.id_barrier);

	// Same barrier still in flight, wait for its write back
	assign hazard = hit_s1 || hit_s2 || hit_s3;

	// Take the head only when it can go all the way through
	assign pop = head_valid && !hazard && !release_almost_full;

	// Slot state lives one cycle per account
	always_ff @(posedge clk) begin
		if (!reset)
			s1_state <= slot_empty;
		else if (pop)
			s1_state <= slot_busy;
		else
			s1_state <= slot_empty;
	end

	// Payload
	always_ff @(posedge clk) begin
		if (pop)
			s1_mess <= head;
	end

endmodule

/* hw/sync_barrier_update.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Barrier memory read and update stages
// Counts arrivals per barrier and emits releases
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module sync_barrier_update import sync_pkg::*; (
	input logic clk,
	input logic reset,
	// From intake
	input sync_account_message_t s1_mess,
	input slot_state_t s1_state,
	// Back to intake for the hazard check
	output logic [barrier_id_width-1:0] s2_id,
	output logic [barrier_id_width-1:0] s3_id,
	output slot_state_t s2_state,
	output slot_state_t s3_state,
	// To release queue
	output logic release_push,
	output sync_release_info_t release_info
);

	// One entry per barrier
	barrier_data_t barrier_mem [barrier_count];

	// Stage 2 holds the account while it reads the memory
	sync_account_message_t s2_mess;

	// Stage 3 holds the account and the entry read for it
	sync_account_message_t s3_mess;
	barrier_data_t s3_data;

	// Updated entry
	barrier_data_t s3_next;
	logic s3_done;

	// Slot states, no stall downstream of intake
	always_ff @(posedge clk) begin
		if (!reset) begin
			s2_state <= slot_empty;
			s3_state <= slot_empty;
		end else begin
			s2_state <= s1_state;
			s3_state <= s2_state;
		end
	end

	// Payloads move along every cycle
	always_ff @(posedge clk) begin
		s2_mess <= s1_mess;
		s3_mess <= s2_mess;
		// Memory read for stage 2
		s3_data <= barrier_mem[s2_mess.id_barrier];
	end

	assign s2_id = s2_mess.id_barrier;
	assign s3_id = s3_mess.id_barrier;

	// One more arrival, mark the sender
	assign s3_next.arrived = s3_data.arrived + count_width'(1);
	assign s3_next.arrived_mask = s3_data.arrived_mask | (tile_mask_t'(1) << s3_mess.tile_id);

	// Last participant in
	assign s3_done = (s3_next.arrived == s3_mess.cnt_setup);

	// Write back, or free the entry for reuse when the barrier completes
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < barrier_count; i++)
				barrier_mem[i] <= '0;
		end else if (s3_state == slot_busy) begin
			if (s3_done)
				barrier_mem[s3_mess.id_barrier] <= '0;
			else
				barrier_mem[s3_mess.id_barrier] <= s3_next;
		end
	end

	// Release goes to every tile that took part
	assign release_push = (s3_state == slot_busy) && s3_done;
	assign release_info.message.id_barrier = s3_mess.id_barrier;
	assign release_info.destinations = s3_next.arrived_mask;

endmodule

/* hw/sync_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO
// Circular buffer with occupancy count and almost-full flag
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module sync_fifo #(
	parameter int width = 8,
	parameter int depth = 8,
	parameter int threshold = 7
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic [width-1:0] din,
	output logic [width-1:0] dout,
	output logic empty,
	output logic almost_full
);

	localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_width = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [cnt_width-1:0] count;
	logic do_push;
	logic do_pop;

	// Wrap at depth, which need not be a power of two
	function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
		if (ptr == ptr_width'(depth - 1))
			return '0;
		return ptr + ptr_width'(1);
	endfunction

	// Push when full and pop when empty are dropped
	assign do_push = push && (count < cnt_width'(depth));
	assign do_pop = pop && (count != '0);

	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Count moves only when exactly one side acts
			if (do_push && !do_pop)
				count <= count + cnt_width'(1);
			else if (do_pop && !do_push)
				count <= count - cnt_width'(1);
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	// Head is shown without a pop
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign almost_full = (count >= cnt_width'(threshold));

endmodule

/* hw/sync_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Barrier sync core shared definitions
// Sizes, message formats, barrier entry and slot state
// ~~~~~~~~~~~~~~~~~~~~

package sync_pkg;

	// Tile and barrier space
	localparam int tile_count = 16;
	localparam int barrier_count = 16;
	localparam int barrier_id_width = 4;
	localparam int tile_id_width = 4;

	// Participant count 1 to 16 needs five bits
	localparam int count_width = 5;

	// Account queue, almost full one slot early so a held sender never overruns
	localparam int account_fifo_depth = 8;
	localparam int account_almost_full = 7;

	// Release queue keeps 4 slots free for releases still in the pipeline
	localparam int release_fifo_depth = 8;
	localparam int release_almost_full = 4;

	// One bit per tile
	typedef logic [tile_count-1:0] tile_mask_t;

	// Account from a tile reaching a barrier
	typedef struct packed {
		logic [barrier_id_width-1:0] id_barrier;
		logic [tile_id_width-1:0] tile_id;
		// Expected number of participants
		logic [count_width-1:0] cnt_setup;
	} sync_account_message_t;

	// Release sent back to all participants
	typedef struct packed {
		logic [barrier_id_width-1:0] id_barrier;
	} sync_release_message_t;

	// Release queue word
	typedef struct packed {
		sync_release_message_t message;
		tile_mask_t destinations;
	} sync_release_info_t;

	// One barrier memory entry
	typedef struct packed {
		// Accounts seen so far
		logic [count_width-1:0] arrived;
		// Tiles that have arrived
		tile_mask_t arrived_mask;
	} barrier_data_t;

	// Occupancy of a pipeline slot
	typedef enum logic {
		slot_empty = 1'b0,
		slot_busy = 1'b1
	} slot_state_t;

endpackage

/* hw/synchronization_core.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Barrier synchronization core of one tile
// Account queue, intake, barrier update and release queue
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module synchronization_core import sync_pkg::*; (
	input logic clk,
	input logic reset,
	// Accounts from the network
	input sync_account_message_t ni_account_mess,
	input logic ni_account_mess_valid,
	output logic account_available,
	output logic sc_account_consumed,
	// Releases to the network
	output sync_release_message_t sc_release_mess,
	output tile_mask_t sc_release_dest_valid,
	output logic sc_release_valid,
	input logic ni_available
);

	// Account queue side
	sync_account_message_t account_head;
	logic account_empty;
	logic account_af;
	logic account_pop;

	// Pipeline
	sync_account_message_t s1_mess;
	slot_state_t s1_state;
	logic [barrier_id_width-1:0] s2_id;
	logic [barrier_id_width-1:0] s3_id;
	slot_state_t s2_state;
	slot_state_t s3_state;

	// Release queue side
	logic release_push;
	sync_release_info_t release_in;
	sync_release_info_t release_head;
	logic release_empty;
	logic release_af;

	// Input handshake, taken in the same cycle it is offered
	assign account_available = !account_af;
	assign sc_account_consumed = ni_account_mess_valid && account_available;

	sync_fifo #(
		.width($bits(sync_account_message_t)),
		.depth(account_fifo_depth),
		.threshold(account_almost_full)
	) i_account_fifo (
		.clk(clk),
		.reset(reset),
		.push(sc_account_consumed),
		.pop(account_pop),
		.din(ni_account_mess),
		.dout(account_head),
		.empty(account_empty),
		.almost_full(account_af)
	);

	sync_account_intake i_intake (
		.clk(clk),
		.reset(reset),
		.head(account_head),
		.head_valid(!account_empty),
		.pop(account_pop),
		.release_almost_full(release_af),
		.s2_id(s2_id),
		.s3_id(s3_id),
		.s2_state(s2_state),
		.s3_state(s3_state),
		.s1_mess(s1_mess),
		.s1_state(s1_state)
	);

	sync_barrier_update i_update (
		.clk(clk),
		.reset(reset),
		.s1_mess(s1_mess),
		.s1_state(s1_state),
		.s2_id(s2_id),
		.s3_id(s3_id),
		.s2_state(s2_state),
		.s3_state(s3_state),
		.release_push(release_push),
		.release_info(release_in)
	);

	sync_fifo #(
		.width($bits(sync_release_info_t)),
		.depth(release_fifo_depth),
		.threshold(release_almost_full)
	) i_release_fifo (
		.clk(clk),
		.reset(reset),
		.push(release_push),
		.pop(sc_release_valid && ni_available),
		.din(release_in),
		.dout(release_head),
		.empty(release_empty),
		.almost_full(release_af)
	);

	// Head of the release queue waits for the network
	assign sc_release_valid = !release_empty;
	assign sc_release_mess = release_head.message;
	assign sc_release_dest_valid = release_head.destinations;

endmodule

/* project.f */
hw/sync_pkg.sv
hw/sync_fifo.sv
hw/sync_account_intake.sv
hw/sync_barrier_update.sv
hw/synchronization_core.sv
verification/synchronization_core_sva.sv
verification/synchronization_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the barrier sync core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ns -f project.f \
	--top-module synchronization_core_tb -Mdir obj_dir
./obj_dir/Vsynchronization_core_tb | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

/* verification/synchronization_core_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Barrier sync core assertions
// Handshake and pipeline invariants
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module synchronization_core_sva import sync_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sc_account_consumed,
	input logic account_empty,
	input logic sc_release_valid,
	input logic ni_available,
	input sync_release_message_t sc_release_mess,
	input tile_mask_t sc_release_dest_valid,
	input slot_state_t s2_state,
	input slot_state_t s3_state,
	input logic [barrier_id_width-1:0] s2_id,
	input logic [barrier_id_width-1:0] s3_id
);

	// Accepted account shows at the queue head one cycle later
	a_account_queued: assert property (@(posedge clk) disable iff (!reset)
		sc_account_consumed |=> !account_empty)
		else $error("accepted account missing from the account queue");

	// Release waiting for the network holds still
	a_release_hold: assert property (@(posedge clk) disable iff (!reset)
		sc_release_valid && !ni_available |=> sc_release_valid
			&& $stable(sc_release_mess) && $stable(sc_release_dest_valid))
		else $error("release changed while the network was busy");

	// Hazard stall keeps one barrier per pipeline
	a_hazard: assert property (@(posedge clk) disable iff (!reset)
		(s2_state == slot_busy) && (s3_state == slot_busy) |-> s2_id != s3_id)
		else $error("same barrier in stage 2 and stage 3");

endmodule

/* verification/synchronization_core_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Barrier sync core testbench
// Table driven accounts, reference model and release monitor
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module synchronization_core_tb import sync_pkg::*; ();

	// One account to send and its lead-in
	typedef struct packed {
		logic [2:0] test;
		logic [barrier_id_width-1:0] barrier;
		logic [tile_id_width-1:0] tile;
		logic [count_width-1:0] cnt;
		// Idle cycles with ni_available low before the account
		logic [7:0] idle;
	} stim_row_t;

	logic clk;
	logic reset;
	sync_account_message_t ni_account_mess;
	logic ni_account_mess_valid;
	logic account_available;
	logic sc_account_consumed;
	sync_release_message_t sc_release_mess;
	tile_mask_t sc_release_dest_valid;
	logic sc_release_valid;
	logic ni_available;

	stim_row_t table_rows [$];
	sync_release_info_t expected_q [$];
	// Reference model state per barrier
	logic [count_width-1:0] model_cnt [barrier_count];
	tile_mask_t model_mask [barrier_count];

	logic [15:0] lfsr_state;
	logic bp_mode;
	int refused;
	int errors;
	int test_errors_start;
	int tests_passed;
	int tests_failed;
	int cycle_count;
	int cycle_limit = 1000000;

	synchronization_core i_dut (
		.clk(clk),
		.reset(reset),
		.ni_account_mess(ni_account_mess),
		.ni_account_mess_valid(ni_account_mess_valid),
		.account_available(account_available),
		.sc_account_consumed(sc_account_consumed),
		.sc_release_mess(sc_release_mess),
		.sc_release_dest_valid(sc_release_dest_valid),
		.sc_release_valid(sc_release_valid),
		.ni_available(ni_available)
	);

	bind synchronization_core synchronization_core_sva i_sva (.*);

	always #2 clk = ~clk;

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_next_bit();
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		return lfsr_state[0];
	endfunction

	function automatic string test_name(input logic [2:0] test);
		case (test)
			3'd1: return "single participant";
			3'd2: return "four tiles";
			3'd3: return "interleaved barriers";
			3'd4: return "barrier reuse";
			3'd5: return "release back-pressure";
			default: return "reset state";
		endcase
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("ERR %0t ns: %s", $time, msg);
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic check_release(input sync_release_message_t got, input sync_release_message_t exp);
		if (got !== exp)
			report_mismatch($sformatf("release barrier %0d, expected %0d",
				got.id_barrier, exp.id_barrier));
	endtask

	task automatic check_mask(input tile_mask_t got, input tile_mask_t exp);
		if (got !== exp)
			report_mismatch($sformatf("release mask %h, expected %h", got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic add_row(input int test, input int barrier, input int tile, input int cnt,
			input int idle);
		stim_row_t row;
		row.test = 3'(test);
		row.barrier = barrier_id_width'(barrier);
		row.tile = tile_id_width'(tile);
		row.cnt = count_width'(cnt);
		row.idle = 8'(idle);
		table_rows.push_back(row);
	endtask

	task automatic build_table();
		add_row(1, 3, 5, 1, 2);
		// Four tiles meet at barrier 1
		add_row(2, 1, 0, 4, 3);
		add_row(2, 1, 4, 4, 3);
		add_row(2, 1, 9, 4, 3);
		add_row(2, 1, 15, 4, 3);
		// Barrier 2 gets back to back accounts, hits the hazard stall
		add_row(3, 2, 1, 3, 0);
		add_row(3, 6, 2, 2, 0);
		add_row(3, 2, 3, 3, 0);
		add_row(3, 2, 7, 3, 0);
		add_row(3, 6, 8, 2, 0);
		// Old masks must not leak into the reused entries
		add_row(4, 3, 1, 2, 0);
		add_row(4, 3, 2, 2, 6);
		add_row(4, 1, 2, 3, 0);
		add_row(4, 1, 3, 3, 6);
		add_row(4, 1, 4, 3, 0);
		// Bursts of single releases with long network stalls
		for (int i = 0; i < 24; i++)
			add_row(5, i % 16, (i * 5) % 16, 1, (i % 8 == 7) ? 12 : 0);
	endtask

	// Network availability for the coming cycle
	task automatic set_available();
		ni_available = bp_mode ? (lfsr_next_bit() & lfsr_next_bit()) : 1'b1;
	endtask

	// Count the arrival, queue a release when the barrier fills
	task automatic model_account(input stim_row_t row);
		sync_release_info_t exp;
		model_cnt[row.barrier] = model_cnt[row.barrier] + count_width'(1);
		model_mask[row.barrier] = model_mask[row.barrier] | (tile_mask_t'(1) << row.tile);
		if (model_cnt[row.barrier] == row.cnt) begin
			exp.message.id_barrier = row.barrier;
			exp.destinations = model_mask[row.barrier];
			expected_q.push_back(exp);
			model_cnt[row.barrier] = '0;
			model_mask[row.barrier] = '0;
		end
	endtask

	task automatic send_account(input stim_row_t row);
		repeat (row.idle) begin
			@(negedge clk);
			ni_account_mess_valid = 1'b0;
			ni_available = 1'b0;
		end
		@(negedge clk);
		ni_account_mess.id_barrier = row.barrier;
		ni_account_mess.tile_id = row.tile;
		ni_account_mess.cnt_setup = row.cnt;
		ni_account_mess_valid = 1'b1;
		set_available();
		@(posedge clk);
		// Refused, hold the same account
		while (!account_available) begin
			refused++;
			@(negedge clk);
			set_available();
			@(posedge clk);
		end
		check_flag(sc_account_consumed, 1'b1, "sc_account_consumed");
		model_account(row);
	endtask

	task automatic close_test(input logic [2:0] test);
		if (errors == test_errors_start) begin
			tests_passed++;
			$display("test %0d (%s): ok", test, test_name(test));
		end else begin
			tests_failed++;
			$display("test %0d (%s): %0d errors", test, test_name(test),
				errors - test_errors_start);
		end
		test_errors_start = errors;
	endtask

	// Wait for every expected release, then watch for extras
	task automatic finish_test(input logic [2:0] test);
		@(negedge clk);
		ni_account_mess_valid = 1'b0;
		set_available();
		while (expected_q.size() != 0) begin
			@(negedge clk);
			set_available();
		end
		repeat (8) begin
			@(negedge clk);
			ni_available = 1'b1;
		end
		if (test == 3'd5 && refused == 0)
			note_failure("Back-pressure test never saw account_available low");
		close_test(test);
	endtask

	// Release monitor
	always @(posedge clk) begin
		sync_release_info_t exp;
		if (reset && sc_release_valid && ni_available) begin
			if (expected_q.size() == 0) begin
				note_failure($sformatf("Release for barrier %0d delivered with none expected",
					sc_release_mess.id_barrier));
			end else begin
				exp = expected_q.pop_front();
				check_release(sc_release_mess, exp.message);
				check_mask(sc_release_dest_valid, exp.destinations);
			end
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, releases still outstanding", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		logic [2:0] cur;
		clk = 1'b0;
		reset = 1'b0;
		ni_account_mess = '0;
		ni_account_mess_valid = 1'b0;
		ni_available = 1'b0;
		lfsr_state = 16'd50;
		bp_mode = 1'b0;
		refused = 0;
		errors = 0;
		test_errors_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycle_count = 0;
		for (int b = 0; b < barrier_count; b++) begin
			model_cnt[b] = '0;
			model_mask[b] = '0;
		end
		build_table();
		cycle_limit = table_rows.size() * 40 + 200;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		ni_available = 1'b1;
		// Idle core after reset, the monitor flags any release
		check_flag(sc_release_valid, 1'b0, "sc_release_valid after reset");
		check_flag(account_available, 1'b1, "account_available after reset");
		repeat (10) @(negedge clk);
		close_test(3'd6);
		cur = 3'd0;
		foreach (table_rows[i]) begin
			if (table_rows[i].test != cur) begin
				if (cur != 3'd0)
					finish_test(cur);
				cur = table_rows[i].test;
				bp_mode = (cur == 3'd5);
				refused = 0;
			end
			send_account(table_rows[i]);
		end
		finish_test(cur);
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
